/* id_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module id_decoder #(
  parameter int unsigned RegCount = 32
) (
  input  id_pkg::word_t     instr_i,
  output id_pkg::dec_ctrl_t ctrl_o,
  output id_pkg::imm_set_t  imm_o,
  output logic              illegal_insn_o
);

  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [1:0]        ls_type;
  logic              rs1_used;
  logic              rs2_used;
  logic              rd_used;
  logic              enc_illegal;
  logic              reg_illegal;
  id_pkg::dec_ctrl_t ctrl_dec;

  // Shared by OP and OP-IMM, alt selects SUB and SRA
  function automatic id_pkg::alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
    unique case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  assign imm_o.i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_o.s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_o.b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
  assign imm_o.u_type = {instr_i[31:12], 12'b0};
  assign imm_o.j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21],
                         1'b0};

  // Byte, half and word sizes in LSU encoding
  always_comb begin
    unique case (funct3[1:0])
      2'b00:   ls_type = 2'b10;
      2'b01:   ls_type = 2'b01;
      default: ls_type = 2'b00;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_dec           = '0;
    ctrl_dec.op_a_sel  = id_pkg::OP_A_REG_A;
    ctrl_dec.op_b_sel  = id_pkg::OP_B_IMM;
    ctrl_dec.imm_b_sel = id_pkg::IMM_B_I;
    ctrl_dec.alu_op    = id_pkg::ALU_ADD;
    ctrl_dec.rf_wd_sel = id_pkg::RF_WD_EX;
    ctrl_dec.rs1       = instr_i[19:15];
    ctrl_dec.rs2       = instr_i[24:20];
    ctrl_dec.rd        = instr_i[11:7];
    rs1_used           = 1'b0;
    rs2_used           = 1'b0;
    rd_used            = 1'b0;
    enc_illegal        = 1'b0;

    unique case (id_pkg::opcode_e'(instr_i[6:0]))
      id_pkg::OPCODE_OP: begin
        rs1_used          = 1'b1;
        rs2_used          = 1'b1;
        rd_used           = 1'b1;
        ctrl_dec.rf_we    = 1'b1;
        ctrl_dec.op_b_sel = id_pkg::OP_B_REG_B;
        ctrl_dec.alu_op   = alu_from_funct3(funct3, funct7[5]);
        // Only SUB and SRA take the alternate funct7
        if (funct7 == 7'h20) begin
          enc_illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          enc_illegal = (funct7 != 7'h00);
        end
      end

      id_pkg::OPCODE_OP_IMM: begin
        rs1_used        = 1'b1;
        rd_used         = 1'b1;
        ctrl_dec.rf_we  = 1'b1;
        ctrl_dec.alu_op = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        // Shift amounts leave funct7 for the shift kind
        if (funct3 == 3'b001) begin
          enc_illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          enc_illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end

      id_pkg::OPCODE_LUI: begin
        rd_used            = 1'b1;
        ctrl_dec.rf_we     = 1'b1;
        ctrl_dec.op_a_sel  = id_pkg::OP_A_ZERO;
        ctrl_dec.imm_b_sel = id_pkg::IMM_B_U;
      end

      id_pkg::OPCODE_LOAD: begin
        rs1_used               = 1'b1;
        rd_used                = 1'b1;
        ctrl_dec.rf_we         = 1'b1;
        ctrl_dec.rf_wd_sel     = id_pkg::RF_WD_LSU;
        ctrl_dec.data_req      = 1'b1;
        ctrl_dec.data_type     = ls_type;
        ctrl_dec.data_sign_ext = ~funct3[2];
        enc_illegal            = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end

      id_pkg::OPCODE_STORE: begin
        rs1_used           = 1'b1;
        rs2_used           = 1'b1;
        ctrl_dec.imm_b_sel = id_pkg::IMM_B_S;
        ctrl_dec.data_req  = 1'b1;
        ctrl_dec.data_we   = 1'b1;
        ctrl_dec.data_type = ls_type;
        enc_illegal        = funct3[2] || (funct3[1:0] == 2'b11);
      end

      id_pkg::OPCODE_BRANCH: begin
        rs1_used           = 1'b1;
        rs2_used           = 1'b1;
        ctrl_dec.branch    = 1'b1;
        ctrl_dec.op_b_sel  = id_pkg::OP_B_REG_B;
        ctrl_dec.imm_b_sel = id_pkg::IMM_B_B;
        unique case (funct3)
          3'b000:  ctrl_dec.alu_op = id_pkg::ALU_EQ;
          3'b001:  ctrl_dec.alu_op = id_pkg::ALU_NE;
          3'b100:  ctrl_dec.alu_op = id_pkg::ALU_LT;
          3'b101:  ctrl_dec.alu_op = id_pkg::ALU_GE;
          3'b110:  ctrl_dec.alu_op = id_pkg::ALU_LTU;
          3'b111:  ctrl_dec.alu_op = id_pkg::ALU_GEU;
          default: enc_illegal     = 1'b1;
        endcase
      end

      id_pkg::OPCODE_JAL: begin
        // EX adds PC and 4 for the link value
        rd_used            = 1'b1;
        ctrl_dec.rf_we     = 1'b1;
        ctrl_dec.jump      = 1'b1;
        ctrl_dec.op_a_sel  = id_pkg::OP_A_CURRPC;
        ctrl_dec.imm_b_sel = id_pkg::IMM_B_INCR_PC;
      end

      default: enc_illegal = 1'b1;
    endcase
  end

  // Indices beyond the implemented registers
  assign reg_illegal = (rs1_used && (int'(ctrl_dec.rs1) >= RegCount)) ||
                       (rs2_used && (int'(ctrl_dec.rs2) >= RegCount)) ||
                       (rd_used  && (int'(ctrl_dec.rd)  >= RegCount));

  assign illegal_insn_o = enc_illegal | reg_illegal;

  // Illegal instructions request nothing
  always_comb begin
    ctrl_o = ctrl_dec;
    if (illegal_insn_o) begin
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.data_req = 1'b0;
      ctrl_o.data_we  = 1'b0;
      ctrl_o.branch   = 1'b0;
      ctrl_o.jump     = 1'b0;
    end
  end

  // FSM picks its path from exactly one class
  always_comb begin
    a_class_onehot: assert ($onehot0({ctrl_o.data_req, ctrl_o.branch, ctrl_o.jump}))
      else $error("Decoder raised more than one instruction class");
  end

endmodule

`default_nettype wire

/* id_operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux (
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::imm_set_t  imm_i,
  input  id_pkg::word_t     rdata_a_i,
  input  id_pkg::word_t     rdata_b_i,
  input  id_pkg::word_t     pc_i,
  output id_pkg::ex_req_t   ex_req_o,
  output id_pkg::lsu_req_t  lsu_req_o
);

  id_pkg::word_t operand_a;
  id_pkg::word_t imm_b;

  //////////////////////////////////////////////////////////////////////
  // Operand A
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.op_a_sel)
      id_pkg::OP_A_REG_A:  operand_a = rdata_a_i;
      id_pkg::OP_A_CURRPC: operand_a = pc_i;
      default:             operand_a = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Operand B
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.imm_b_sel)
      id_pkg::IMM_B_I:       imm_b = imm_i.i_type;
      id_pkg::IMM_B_S:       imm_b = imm_i.s_type;
      id_pkg::IMM_B_B:       imm_b = imm_i.b_type;
      id_pkg::IMM_B_U:       imm_b = imm_i.u_type;
      id_pkg::IMM_B_J:       imm_b = imm_i.j_type;
      id_pkg::IMM_B_INCR_PC: imm_b = id_pkg::PcIncr;
      default:               imm_b = '0;
    endcase
  end

  assign ex_req_o.alu_op    = ctrl_i.alu_op;
  assign ex_req_o.operand_a = operand_a;
  assign ex_req_o.operand_b = (ctrl_i.op_b_sel == id_pkg::OP_B_IMM) ? imm_b : rdata_b_i;

  // LSU request, address comes from the ALU
  assign lsu_req_o.we        = ctrl_i.data_we;
  assign lsu_req_o.data_type = ctrl_i.data_type;
  assign lsu_req_o.sign_ext  = ctrl_i.data_sign_ext;
  assign lsu_req_o.wdata     = rdata_b_i;

endmodule

`default_nettype wire

/* id_pkg.sv */
`default_nettype none

package id_pkg;

  // Data word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // Arithmetic ops first, then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic {
    RF_WD_EX,
    RF_WD_LSU
  } rf_wd_sel_e;

  typedef enum logic {
    IDLE,
    WAIT_MULTICYCLE
  } id_fsm_e;

  // Decoded control of the held instruction
  typedef struct packed {
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    alu_op_e    alu_op;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       rf_we;
    rf_wd_sel_e rf_wd_sel;
    logic       data_req;      // load/store class
    logic       data_we;
    logic [1:0] data_type;     // 00 word, 01 half, 10 byte
    logic       data_sign_ext;
    logic       branch;
    logic       jump;
  } dec_ctrl_t;

  typedef struct packed {
    word_t i_type;
    word_t s_type;
    word_t b_type;
    word_t u_type;
    word_t j_type;
  } imm_set_t;

  typedef struct packed {
    alu_op_e alu_op;
    word_t   operand_a;
    word_t   operand_b;
  } ex_req_t;

  typedef struct packed {
    logic       we;
    logic [1:0] data_type;
    logic       sign_ext;
    word_t      wdata;
  } lsu_req_t;

  // Link value for JAL, no compressed instructions
  localparam word_t PcIncr = 32'd4;

endpackage

`default_nettype wire

/* id_register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module id_register_file #(
  parameter int unsigned RegCount = 32
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  id_pkg::reg_addr_t raddr_a_i,
  input  id_pkg::reg_addr_t raddr_b_i,
  input  id_pkg::reg_addr_t waddr_i,
  input  id_pkg::word_t     wdata_i,
  input  logic              we_i,
  output id_pkg::word_t     rdata_a_o,
  output id_pkg::word_t     rdata_b_o
);

  id_pkg::word_t regs_q [RegCount];

  // x0 and missing registers read as zero
  function automatic id_pkg::word_t read_reg(id_pkg::reg_addr_t addr);
    if ((addr == '0) || (int'(addr) >= RegCount)) begin
      return '0;
    end
    return regs_q[addr];
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < RegCount; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0) && (int'(waddr_i) < RegCount)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous read ports
  always_comb begin
    rdata_a_o = read_reg(raddr_a_i);
    rdata_b_o = read_reg(raddr_b_i);
  end

  // Decoder flags such indices as illegal, so no write reaches here
  a_waddr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni) we_i |-> (int'(waddr_i) < RegCount)
  ) else $error("Register write to index %0d beyond register count", waddr_i);

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
  parameter int unsigned RegCount = 32
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  // IF side
  input  logic             instr_valid_i,
  input  logic             instr_new_i,
  input  id_pkg::word_t    instr_rdata_i,
  input  id_pkg::word_t    pc_id_i,

  // EX and LSU results
  input  logic             branch_decision_i,
  input  logic             ex_valid_i,
  input  logic             lsu_valid_i,
  input  id_pkg::word_t    regfile_wdata_ex_i,
  input  id_pkg::word_t    regfile_wdata_lsu_i,

  // Requests and status
  output id_pkg::ex_req_t  ex_req_o,
  output id_pkg::lsu_req_t lsu_req_o,
  output logic             data_req_o,
  output logic             illegal_insn_o,
  output logic             id_in_ready_o,
  output logic             instr_ret_o,
  output logic             branch_set_o
);

  id_pkg::dec_ctrl_t ctrl;
  id_pkg::imm_set_t  imm;
  id_pkg::word_t     rdata_a;
  id_pkg::word_t     rdata_b;
  id_pkg::word_t     rf_wdata;
  logic              rf_we;
  logic              instr_new;

  // A new instruction only counts while IF marks it valid
  assign instr_new = instr_new_i & instr_valid_i;

  id_decoder #(
    .RegCount (RegCount)
  ) u_decoder (
    .instr_i        (instr_rdata_i),
    .ctrl_o         (ctrl),
    .imm_o          (imm),
    .illegal_insn_o (illegal_insn_o)
  );

  id_operand_mux u_operand_mux (
    .ctrl_i    (ctrl),
    .imm_i     (imm),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .pc_i      (pc_id_i),
    .ex_req_o  (ex_req_o),
    .lsu_req_o (lsu_req_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Write-back
  //////////////////////////////////////////////////////////////////////

  assign rf_wdata = (ctrl.rf_wd_sel == id_pkg::RF_WD_LSU) ? regfile_wdata_lsu_i
                                                          : regfile_wdata_ex_i;

  id_register_file #(
    .RegCount (RegCount)
  ) u_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (ctrl.rs1),
    .raddr_b_i (ctrl.rs2),
    .waddr_i   (ctrl.rd),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_wb_fsm u_wb_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_new_i       (instr_new),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .illegal_insn_i    (illegal_insn_o),
    .ctrl_i            (ctrl),
    .rf_we_o           (rf_we),
    .data_req_o        (data_req_o),
    .id_in_ready_o     (id_in_ready_o),
    .instr_ret_o       (instr_ret_o),
    .branch_set_o      (branch_set_o)
  );

  // IF holds a fully driven word while it is valid
  a_instr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) instr_valid_i |-> !$isunknown(instr_rdata_i)
  ) else $error("Valid instruction word has unknown bits");

endmodule

`default_nettype wire

/* id_wb_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module id_wb_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_new_i,
  input  logic              branch_decision_i,
  input  logic              ex_valid_i,
  input  logic              lsu_valid_i,
  input  logic              illegal_insn_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  output logic              rf_we_o,
  output logic              data_req_o,
  output logic              id_in_ready_o,
  output logic              instr_ret_o,
  output logic              branch_set_o
);

  id_pkg::id_fsm_e fsm_q;
  id_pkg::id_fsm_e fsm_d;
  logic            multicycle_done_q;
  logic            multicycle_done_d;
  logic            branch_set_d;
  logic            instr_executing;
  logic            wb_deferred;
  logic            rf_we_wb;
  logic            stall_lsu;
  logic            stall_branch;
  logic            stall_jump;

  // Executing from the new cycle until the multicycle op is done
  assign instr_executing = instr_new_i | ~multicycle_done_q;
  assign data_req_o      = instr_executing & ctrl_i.data_req;

  // Loads and JAL write on completion, the rest in their first cycle
  assign wb_deferred = ctrl_i.data_req | ctrl_i.jump;
  assign rf_we_o     = instr_executing & ~illegal_insn_i &
                       (wb_deferred ? rf_we_wb : ctrl_i.rf_we);

  assign id_in_ready_o = ~(stall_lsu | stall_branch | stall_jump);

  //////////////////////////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q             <= id_pkg::IDLE;
      multicycle_done_q <= 1'b1;
      branch_set_o      <= 1'b0;
    end else begin
      fsm_q             <= fsm_d;
      multicycle_done_q <= multicycle_done_d;
      branch_set_o      <= branch_set_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fsm_d             = fsm_q;
    multicycle_done_d = multicycle_done_q;
    branch_set_d      = 1'b0;
    rf_we_wb          = 1'b0;
    stall_lsu         = 1'b0;
    stall_branch      = 1'b0;
    stall_jump        = 1'b0;
    instr_ret_o       = 1'b0;

    unique case (fsm_q)
      id_pkg::IDLE: begin
        // Detect multicycle ops only once per instruction
        if (instr_new_i) begin
          unique case (1'b1)
            ctrl_i.data_req: begin
              fsm_d             = id_pkg::WAIT_MULTICYCLE;
              stall_lsu         = 1'b1;
              multicycle_done_d = 1'b0;
            end
            ctrl_i.branch: begin
              // Not-taken branch retires right away
              fsm_d             = branch_decision_i ? id_pkg::WAIT_MULTICYCLE : id_pkg::IDLE;
              stall_branch      = branch_decision_i;
              multicycle_done_d = ~branch_decision_i;
              branch_set_d      = branch_decision_i;
              instr_ret_o       = ~branch_decision_i;
            end
            ctrl_i.jump: begin
              fsm_d             = id_pkg::WAIT_MULTICYCLE;
              stall_jump        = 1'b1;
              multicycle_done_d = 1'b0;
            end
            default: begin
              instr_ret_o = 1'b1;
            end
          endcase
        end
      end

      id_pkg::WAIT_MULTICYCLE: begin
        if ((ctrl_i.data_req && lsu_valid_i) || (!ctrl_i.data_req && ex_valid_i)) begin
          fsm_d             = id_pkg::IDLE;
          multicycle_done_d = 1'b1;
          rf_we_wb          = ctrl_i.rf_we;
          instr_ret_o       = 1'b1;
        end else begin
          stall_lsu    = ctrl_i.data_req;
          stall_branch = ctrl_i.branch;
          stall_jump   = ctrl_i.jump;
        end
      end

      default: fsm_d = id_pkg::IDLE;
    endcase
  end

  // Completion strobes from EX and LSU must be driven while waiting
  a_valid_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (fsm_q == id_pkg::WAIT_MULTICYCLE) |-> !$isunknown({ex_valid_i, lsu_valid_i})
  ) else $error("EX or LSU valid is unknown while waiting on a multicycle op");

endmodule

`default_nettype wire

/* list.f */
+incdir+.
id_pkg.sv
id_decoder.sv
id_operand_mux.sv
id_register_file.sv
id_wb_fsm.sv
id_stage.sv
tb_id_stage.sv

/* run.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ps \
       -f list.f --top-module tb_id_stage -o tb_id_stage \
  && ./obj_dir/tb_id_stage \
  || { echo "Simulation run did not succeed"; exit 1; }

/* tb_id_vectors.svh */
`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// Longest random wait before a completion strobe
localparam int unsigned MaxWait = 5;

// Columns per row
//   name, instr, pc, branch taken, EX data, LSU data, max wait cycles,
//   alu op, A from rs1, A value, B from rs2, B value, lsu we, type, sign ext, illegal, multicycle
task automatic load_vectors();
  add_vec("addi_pos", 32'h0050_0093, 32'h0000_0100, 1'b0, 32'h0000_0005, 32'h0, 0,
          id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b0, 32'h0000_0005, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("addi_neg", 32'hFFD0_8113, 32'h0000_0104, 1'b0, 32'h0000_0002, 32'h0, 0,
          id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b0, 32'hFFFF_FFFD, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("lui", 32'h1234_51B7, 32'h0000_0108, 1'b0, 32'h1234_5000, 32'h0, 0,
          id_pkg::ALU_ADD, 1'b0, 32'h0, 1'b0, 32'h1234_5000, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("sub", 32'h4011_8233, 32'h0000_010C, 1'b0, 32'h1234_4FFB, 32'h0, 0,
          id_pkg::ALU_SUB, 1'b1, 32'h0, 1'b1, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("xor_rd_x0", 32'h0041_4033, 32'h0000_0110, 1'b0, 32'hDEAD_BEEF, 32'h0, 0,
          id_pkg::ALU_XOR, 1'b1, 32'h0, 1'b1, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("or_reads_x0", 32'h0020_62B3, 32'h0000_0114, 1'b0, 32'h0000_0002, 32'h0, 0,
          id_pkg::ALU_OR, 1'b1, 32'h0, 1'b1, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  // The rd field names x8, which the load below reads as rs2
  add_vec("sw", 32'h0041_2423, 32'h0000_0118, 1'b0, 32'h5EED_0001, 32'h5EED_0002, MaxWait,
          id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b0, 32'h0000_0008, 1'b1, 2'b00, 1'b0, 1'b0, 1'b1);
  add_vec("lh", 32'hFE82_9303, 32'h0000_011C, 1'b0, 32'h0BAD_F00D, 32'hFFFF_8001, MaxWait,
          id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b0, 32'hFFFF_FFE8, 1'b0, 2'b01, 1'b1, 1'b0, 1'b1);
  add_vec("add_load_use", 32'h0043_03B3, 32'h0000_0120, 1'b0, 32'h1233_CFFC, 32'h0, 0,
          id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b1, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("beq_not_taken", 32'h0020_8863, 32'h0000_0124, 1'b0, 32'h0BAD_0001, 32'h0, 0,
          id_pkg::ALU_EQ, 1'b1, 32'h0, 1'b1, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("bne_taken", 32'hFE20_9CE3, 32'h0000_0128, 1'b1, 32'h0, 32'h0, MaxWait,
          id_pkg::ALU_NE, 1'b1, 32'h0, 1'b1, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b1);
  add_vec("jal", 32'h0100_046F, 32'h0000_0130, 1'b0, 32'h0000_0134, 32'h0, MaxWait,
          id_pkg::ALU_ADD, 1'b0, 32'h0000_0130, 1'b0, 32'h0000_0004, 1'b0, 2'b00, 1'b0, 1'b0,
          1'b1);
  add_vec("jal_link_use", 32'h0004_0493, 32'h0000_0134, 1'b0, 32'h0000_0134, 32'h0, 0,
          id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
  add_vec("illegal_opcode", 32'h0000_00FF, 32'h0000_0138, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
          0, id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b1, 1'b0);
  add_vec("after_illegal", 32'h0000_8513, 32'h0000_013C, 1'b0, 32'h0000_0005, 32'h0, 0,
          id_pkg::ALU_ADD, 1'b1, 32'h0, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0);
endtask

`endif

/* tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  localparam int ClkPeriod = 8;
  localparam int RstCycles = 10;

  // One instruction of the vector table
  typedef struct {
    string           name;
    id_pkg::word_t   instr;
    id_pkg::word_t   pc;
    logic            taken;
    id_pkg::word_t   ex_data;
    id_pkg::word_t   lsu_data;
    int unsigned     max_wait;
    id_pkg::alu_op_e alu_op;
    logic            a_reg;
    id_pkg::word_t   a_val;
    logic            b_reg;
    id_pkg::word_t   b_val;
    logic            lsu_we;
    logic [1:0]      lsu_type;
    logic            lsu_sext;
    logic            illegal;
    logic            multi;
  } vec_t;

  logic             clk_i;
  logic             rst_ni;
  logic             instr_valid_i;
  logic             instr_new_i;
  id_pkg::word_t    instr_rdata_i;
  id_pkg::word_t    pc_id_i;
  logic             branch_decision_i;
  logic             ex_valid_i;
  logic             lsu_valid_i;
  id_pkg::word_t    regfile_wdata_ex_i;
  id_pkg::word_t    regfile_wdata_lsu_i;
  id_pkg::ex_req_t  ex_req_o;
  id_pkg::lsu_req_t lsu_req_o;
  logic             data_req_o;
  logic             illegal_insn_o;
  logic             id_in_ready_o;
  logic             instr_ret_o;
  logic             branch_set_o;

  // Register contents as the write rule predicts them
  id_pkg::word_t model_regs [32];
  vec_t          vecs [$];
  integer        seed;

  id_stage #(
    .RegCount (32)
  ) u_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .instr_new_i         (instr_new_i),
    .instr_rdata_i       (instr_rdata_i),
    .pc_id_i             (pc_id_i),
    .branch_decision_i   (branch_decision_i),
    .ex_valid_i          (ex_valid_i),
    .lsu_valid_i         (lsu_valid_i),
    .regfile_wdata_ex_i  (regfile_wdata_ex_i),
    .regfile_wdata_lsu_i (regfile_wdata_lsu_i),
    .ex_req_o            (ex_req_o),
    .lsu_req_o           (lsu_req_o),
    .data_req_o          (data_req_o),
    .illegal_insn_o      (illegal_insn_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_ret_o         (instr_ret_o),
    .branch_set_o        (branch_set_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Table rows and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic add_vec(input string name, input id_pkg::word_t instr, input id_pkg::word_t pc,
                         input logic taken, input id_pkg::word_t ex_data,
                         input id_pkg::word_t lsu_data, input int unsigned max_wait,
                         input id_pkg::alu_op_e alu_op, input logic a_reg,
                         input id_pkg::word_t a_val, input logic b_reg,
                         input id_pkg::word_t b_val, input logic lsu_we,
                         input logic [1:0] lsu_type, input logic lsu_sext,
                         input logic illegal, input logic multi);
    vec_t v;
    v = '{name, instr, pc, taken, ex_data, lsu_data, max_wait, alu_op, a_reg, a_val,
          b_reg, b_val, lsu_we, lsu_type, lsu_sext, illegal, multi};
    vecs.push_back(v);
  endtask

  `include "tb_id_vectors.svh"

  task automatic abort_run(input string reason);
    $display("Checks failed");
    $fatal(1, "%s", reason);
  endtask

  function automatic string format_lsu(input id_pkg::lsu_req_t r);
    return $sformatf("we %b type %b sext %b wdata %h", r.we, r.data_type, r.sign_ext,
                     r.wdata);
  endfunction

  task automatic check_ex(input string test, input id_pkg::ex_req_t exp,
                          input id_pkg::ex_req_t act);
    if (act !== exp) begin
      $display("[ERROR] %s ex_req: expected op %0d a %h b %h, actual op %0d a %h b %h", test,
               exp.alu_op, exp.operand_a, exp.operand_b, act.alu_op, act.operand_a,
               act.operand_b);
      abort_run("EX request differs from the decode rules");
    end
  endtask

  task automatic check_lsu(input string test, input id_pkg::lsu_req_t exp,
                           input id_pkg::lsu_req_t act);
    if (act !== exp) begin
      $display("[ERROR] %s lsu_req: expected %s, actual %s", test, format_lsu(exp),
               format_lsu(act));
      abort_run("LSU request differs from the decode rules");
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %b, actual %b", test, what, exp, act);
      abort_run("Status strobe has the wrong level");
    end
  endtask

  task automatic raise_done(input logic mem_op);
    if (mem_op) begin
      lsu_valid_i <= 1'b1;
    end else begin
      ex_valid_i <= 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One table row from the new cycle to retire
  //////////////////////////////////////////////////////////////////////

  task automatic run_vector(input vec_t v);
    id_pkg::ex_req_t   exp_ex;
    id_pkg::lsu_req_t  exp_lsu;
    id_pkg::reg_addr_t rs1;
    id_pkg::reg_addr_t rs2;
    id_pkg::reg_addr_t rd;
    logic [6:0]        opcode;
    logic              mem_op;
    logic              branch_op;
    logic              writes;
    int unsigned       wait_n;

    opcode = v.instr[6:0];
    rs1    = v.instr[19:15];
    rs2    = v.instr[24:20];
    rd     = v.instr[11:7];
    mem_op    = !v.illegal && ((opcode == 7'h03) || (opcode == 7'h23));
    branch_op = !v.illegal && (opcode == 7'h63);
    writes    = !v.illegal && ((opcode == 7'h33) || (opcode == 7'h13) || (opcode == 7'h37) ||
                               (opcode == 7'h03) || (opcode == 7'h6f));

    exp_ex.alu_op    = v.alu_op;
    exp_ex.operand_a = v.a_reg ? model_regs[rs1] : v.a_val;
    exp_ex.operand_b = v.b_reg ? model_regs[rs2] : v.b_val;
    exp_lsu.we        = v.lsu_we;
    exp_lsu.data_type = v.lsu_type;
    exp_lsu.sign_ext  = v.lsu_sext;
    exp_lsu.wdata     = model_regs[rs2];

    wait_n = 0;
    if (v.max_wait != 0) begin
      wait_n = $unsigned($random(seed)) % (v.max_wait + 1);
    end

    @(posedge clk_i);
    instr_valid_i       <= 1'b1;
    instr_new_i         <= 1'b1;
    instr_rdata_i       <= v.instr;
    pc_id_i             <= v.pc;
    branch_decision_i   <= v.taken;
    regfile_wdata_ex_i  <= v.ex_data;
    regfile_wdata_lsu_i <= v.lsu_data;

    @(negedge clk_i);
    check_bit(v.name, "illegal_insn", v.illegal, illegal_insn_o);
    if (!v.illegal) begin
      check_ex(v.name, exp_ex, ex_req_o);
    end
    check_lsu(v.name, exp_lsu, lsu_req_o);
    check_bit(v.name, "data_req", mem_op, data_req_o);
    check_bit(v.name, "instr_ret", !v.multi, instr_ret_o);
    check_bit(v.name, "id_in_ready", !v.multi, id_in_ready_o);

    @(posedge clk_i);
    instr_new_i <= 1'b0;
    if (v.multi) begin
      if (wait_n == 0) begin
        raise_done(mem_op);
      end
      for (int k = 0; k <= wait_n; k++) begin
        @(negedge clk_i);
        // Taken branch pulses once right after its first cycle
        check_bit(v.name, "branch_set", (k == 0) && branch_op, branch_set_o);
        check_bit(v.name, "data_req", mem_op, data_req_o);
        check_bit(v.name, "instr_ret", k == wait_n, instr_ret_o);
        check_bit(v.name, "id_in_ready", k == wait_n, id_in_ready_o);
        @(posedge clk_i);
        if (k + 1 == wait_n) begin
          raise_done(mem_op);
        end
      end
      ex_valid_i    <= 1'b0;
      lsu_valid_i   <= 1'b0;
      instr_valid_i <= 1'b0;
    end else begin
      instr_valid_i <= 1'b0;
      @(negedge clk_i);
      check_bit(v.name, "branch_set", 1'b0, branch_set_o);
      check_bit(v.name, "instr_ret", 1'b0, instr_ret_o);
    end

    // Written at the edge that closed the retire cycle
    if (writes && (rd != '0)) begin
      model_regs[rd] = mem_op ? v.lsu_data : v.ex_data;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed                = 32'h390a81f6;
    rst_ni              = 1'b0;
    instr_valid_i       = 1'b0;
    instr_new_i         = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_valid_i         = 1'b0;
    regfile_wdata_ex_i  = '0;
    regfile_wdata_lsu_i = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    load_vectors();

    repeat (RstCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("reset", "data_req", 1'b0, data_req_o);
    check_bit("reset", "instr_ret", 1'b0, instr_ret_o);
    check_bit("reset", "branch_set", 1'b0, branch_set_o);
    check_bit("reset", "id_in_ready", 1'b1, id_in_ready_o);

    for (int i = 0; i < vecs.size(); i++) begin
      run_vector(vecs[i]);
    end

    $display("All checks passed");
    $finish;
  end

  initial begin
    int limit;

    // Rows are loaded at time zero
    #1;
    limit = (RstCycles + 2 + vecs.size() * (MaxWait + 4)) * ClkPeriod;
    #(limit);
    abort_run("Watchdog expired before all table rows retired");
  end

endmodule

`default_nettype wire
